// File: fpap_top.f
source/fpap_pkg.sv
source/sram_bank.sv
source/act_buffer.sv
source/weight_buffer.sv
source/fir_row.sv
source/out_buffer.sv
source/fpap_top.sv
bench/fpap_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= fpap_tb
RTL_TOP    ?= fpap_top
FILELIST   ?= fpap_top.f
RTL_FILES  ?= $(filter source/%,$(shell cat $(FILELIST)))
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Result: PASSED
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fpap_tb.sv
`timescale 1ns/10ps

module fpap_tb;

    import fpap_pkg::*;

    localparam int num_rows = 4;
    localparam int nb_taps = 5;
    localparam int act_aw = $clog2(ACT_DEPTH);
    localparam int wbuff_aw = $clog2(WBUFF_DEPTH);
    localparam int out_aw = $clog2(OUT_DEPTH);
    localparam longint out_max = (64'sd1 <<< (OUT_WIDTH - 1)) - 1;
    localparam longint out_min = -(64'sd1 <<< (OUT_WIDTH - 1));
    localparam int timeout_cycles = 200;

    logic clk;
    logic rst_n;
    logic [num_rows-1:0] act_wr_en;
    logic [num_rows-1:0] act_rd_en;
    logic [num_rows-1:0][act_aw-1:0] act_waddr;
    logic [num_rows-1:0][act_aw-1:0] act_raddr;
    act_t [num_rows-1:0] act_wdata;
    act_t [num_rows-1:0] dummy_act;
    logic act_src_sel;
    logic wbuff_wr_en;
    logic wbuff_rd_en;
    logic [wbuff_aw-1:0] wbuff_waddr;
    logic [wbuff_aw-1:0] wbuff_raddr;
    weight_t wbuff_data;
    logic [nb_taps-1:0] tap_load_en;
    logic wreg_clear;
    logic [num_rows-1:0] out_rd_en;
    logic [num_rows-1:0][out_aw-1:0] out_raddr;
    result_t [num_rows-1:0] out_data;

    // reference state
    longint tap_model [nb_taps];
    longint hist [num_rows][nb_taps]; // tap 0 newest
    longint exp_mem [num_rows][OUT_DEPTH];
    act_t stim [num_rows][32];
    longint read_exp [num_rows];
    longint chk_exp [num_rows];
    logic [num_rows-1:0] chk_en;
    int wr_count = 0;
    int sent_total = 0;
    int results_seen = 0;
    int error_count = 0;
    int check_count = 0;
    bit timed_out = 1'b0;

    fpap_top #(
        .num_pe_row(num_rows),
        .nb_taps   (nb_taps)
    ) dut_i (
        .clk(clk), .rst_n(rst_n),
        .act_wr_en(act_wr_en), .act_rd_en(act_rd_en),
        .act_waddr(act_waddr), .act_raddr(act_raddr),
        .act_wdata(act_wdata), .dummy_act(dummy_act), .act_src_sel(act_src_sel),
        .wbuff_wr_en(wbuff_wr_en), .wbuff_rd_en(wbuff_rd_en),
        .wbuff_waddr(wbuff_waddr), .wbuff_raddr(wbuff_raddr), .wbuff_data(wbuff_data),
        .tap_load_en(tap_load_en), .wreg_clear(wreg_clear),
        .out_rd_en(out_rd_en), .out_raddr(out_raddr), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // **************************************************
    // reference model and checking
    // **************************************************
    function automatic longint filter_ref(input longint window [nb_taps],
                                          input longint coef [nb_taps]);
        longint acc;
        acc = 0;
        for (int k = 0; k < nb_taps; k++) begin
            acc += window[k] * coef[k];
        end
        if (acc > out_max) begin
            return out_max;
        end
        return (acc < out_min) ? out_min : acc;
    endfunction

    task automatic check_value(input logic signed [63:0] actual,
                               input logic signed [63:0] expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    always @(posedge clk) begin
        chk_en  <= out_rd_en; // read data shows up one cycle later
        chk_exp <= read_exp;
    end

    always @(negedge clk) begin
        for (int r = 0; r < num_rows; r++) begin
            if (chk_en[r]) begin
                check_value(64'($signed(out_data[r])), chk_exp[r],
                            $sformatf("row %0d result", r));
            end
        end
        if (rst_n) begin
            results_seen <= results_seen + $countones(dut_i.result_valid);
        end
    end

    // **************************************************
    // stimulus
    // **************************************************
    task automatic load_taps(input longint vals [nb_taps], input logic [nb_taps-1:0] mask,
                             input int base);
        for (int k = 0; k < nb_taps; k++) begin
            @(negedge clk);
            wbuff_wr_en = 1'b1;
            wbuff_waddr = wbuff_aw'(base + k);
            wbuff_data  = weight_t'(vals[k]);
        end
        @(negedge clk);
        wbuff_wr_en = 1'b0;
        for (int k = 0; k < nb_taps; k++) begin
            if (mask[k]) begin
                @(negedge clk);
                wbuff_rd_en = 1'b1;
                wbuff_raddr = wbuff_aw'(base + k);
                tap_load_en = nb_taps'(1 << k);
                tap_model[k] = vals[k];
            end
        end
        @(negedge clk);
        wbuff_rd_en = 1'b0;
        tap_load_en = '0;
        @(negedge clk); // last tap register loads here
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (results_seen < sent_total && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (results_seen < sent_total) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d filter results arrived", results_seen, sent_total);
        end
        @(negedge clk);
    endtask

    task automatic read_back(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            out_rd_en = '1;
            for (int r = 0; r < num_rows; r++) begin
                out_raddr[r] = out_aw'(first + i);
                read_exp[r]  = exp_mem[r][first + i];
            end
        end
        @(negedge clk);
        out_rd_en = '0;
    endtask

    // fill, stream one per cycle on all rows, then read the results back
    task automatic run_burst(input int count, input bit from_bank, input bit extreme);
        longint win [nb_taps];
        int first;
        if (timed_out) begin
            return;
        end
        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < count; i++) begin
                if (extreme) begin
                    stim[r][i] = (((i / nb_taps) + r) % 2 == 1) ? act_t'(16'sh8000)
                                                                : act_t'(16'sh7fff);
                end else begin
                    stim[r][i] = act_t'(int'($urandom_range(4095)) - 2048);
                end
            end
        end
        if (from_bank) begin
            for (int i = 0; i < count; i++) begin
                @(negedge clk);
                act_wr_en = '1;
                for (int r = 0; r < num_rows; r++) begin
                    act_waddr[r] = act_aw'(i);
                    act_wdata[r] = stim[r][i];
                end
            end
            @(negedge clk);
            act_wr_en = '0;
        end
        first = wr_count;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            act_rd_en   = '1;
            act_src_sel = from_bank;
            for (int r = 0; r < num_rows; r++) begin
                act_raddr[r] = act_aw'(i);
                dummy_act[r] = stim[r][i];
                for (int k = nb_taps - 1; k > 0; k--) begin
                    hist[r][k] = hist[r][k-1];
                end
                hist[r][0] = longint'(stim[r][i]);
                for (int k = 0; k < nb_taps; k++) begin
                    win[k] = hist[r][k];
                end
                exp_mem[r][wr_count] = filter_ref(win, tap_model);
            end
            wr_count++;
        end
        @(negedge clk);
        act_rd_en = '0;
        sent_total += count * num_rows;
        wait_results();
        if (!timed_out) begin
            read_back(first, count);
        end
    endtask

    initial begin
        longint vals [nb_taps];
        void'($urandom(32'h6744));
        rst_n = 1'b0;
        act_wr_en = '0;
        act_rd_en = '0;
        act_waddr = '0;
        act_raddr = '0;
        act_wdata = '0;
        dummy_act = '0;
        act_src_sel = 1'b1;
        wbuff_wr_en = 1'b0;
        wbuff_rd_en = 1'b0;
        wbuff_waddr = '0;
        wbuff_raddr = '0;
        wbuff_data = '0;
        tap_load_en = '0;
        wreg_clear = 1'b0;
        out_rd_en = '0;
        out_raddr = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_back(0, 16); // nothing written yet

        for (int k = 0; k < nb_taps; k++) begin
            vals[k] = longint'($urandom_range(511)) - 256;
        end
        load_taps(vals, '1, 0);
        run_burst(24, 1'b1, 1'b0);
        run_burst(24, 1'b0, 1'b0); // dummy source

        // large taps with runs of extreme samples
        for (int k = 0; k < nb_taps; k++) begin
            vals[k] = 32767;
        end
        load_taps(vals, '1, 8);
        run_burst(20, 1'b1, 1'b1);

        @(negedge clk);
        wreg_clear = 1'b1;
        @(negedge clk);
        wreg_clear = 1'b0;
        tap_model = '{default: 0};
        run_burst(16, 1'b1, 1'b0);

        // partial reloads leave the untouched taps as they are
        for (int k = 0; k < nb_taps; k++) begin
            vals[k] = longint'($urandom_range(511)) - 256;
        end
        load_taps(vals, 5'b10101, 16);
        run_burst(16, 1'b1, 1'b0);
        for (int k = 0; k < nb_taps; k++) begin
            vals[k] = longint'($urandom_range(511)) - 256;
        end
        load_taps(vals, 5'b01010, 24);
        run_burst(16, 1'b0, 1'b0);

        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 int'(timed_out));
        if (error_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: source/fpap_top.sv
`timescale 1ns/10ps

module fpap_top #(
    parameter int num_pe_row = 4,
    parameter int nb_taps = 5,
    parameter int act_depth = fpap_pkg::ACT_DEPTH,
    parameter int wbuff_depth = fpap_pkg::WBUFF_DEPTH,
    parameter int out_depth = fpap_pkg::OUT_DEPTH,
    localparam int act_aw = $clog2(act_depth),
    localparam int wbuff_aw = $clog2(wbuff_depth),
    localparam int out_aw = $clog2(out_depth)
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // activation buffer
    input  logic [num_pe_row-1:0]                act_wr_en,
    input  logic [num_pe_row-1:0]                act_rd_en,
    input  logic [num_pe_row-1:0][act_aw-1:0]    act_waddr,
    input  logic [num_pe_row-1:0][act_aw-1:0]    act_raddr,
    input  fpap_pkg::act_t [num_pe_row-1:0]      act_wdata,
    input  fpap_pkg::act_t [num_pe_row-1:0]      dummy_act,
    input  logic                                 act_src_sel, // 0 selects dummy_act
    // weight buffer
    input  logic                                 wbuff_wr_en,
    input  logic                                 wbuff_rd_en,
    input  logic [wbuff_aw-1:0]                  wbuff_waddr,
    input  logic [wbuff_aw-1:0]                  wbuff_raddr,
    input  fpap_pkg::weight_t                    wbuff_data,
    input  logic [nb_taps-1:0]                   tap_load_en,
    input  logic                                 wreg_clear,
    // output buffer read port
    input  logic [num_pe_row-1:0]                out_rd_en,
    input  logic [num_pe_row-1:0][out_aw-1:0]    out_raddr,
    output fpap_pkg::result_t [num_pe_row-1:0]   out_data
);

    import fpap_pkg::*;

    act_t    [num_pe_row-1:0] act_data;
    logic    [num_pe_row-1:0] act_valid;
    weight_t [nb_taps-1:0]    taps; // shared by all rows
    result_t [num_pe_row-1:0] result;
    logic    [num_pe_row-1:0] result_valid;

    // **************************************************
    // buffers feeding the rows
    // **************************************************
    act_buffer #(
        .num_pe_row(num_pe_row),
        .act_depth (act_depth)
    ) act_buffer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (act_wr_en),
        .waddr    (act_waddr),
        .wdata    (act_wdata),
        .rd_en    (act_rd_en),
        .raddr    (act_raddr),
        .dummy_act(dummy_act),
        .src_sel  (act_src_sel),
        .act_data (act_data),
        .act_valid(act_valid)
    );

    weight_buffer #(
        .nb_taps    (nb_taps),
        .wbuff_depth(wbuff_depth)
    ) weight_buffer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wbuff_wr_en),
        .waddr      (wbuff_waddr),
        .wdata      (wbuff_data),
        .rd_en      (wbuff_rd_en),
        .raddr      (wbuff_raddr),
        .tap_load_en(tap_load_en),
        .wreg_clear (wreg_clear),
        .taps       (taps)
    );

    for (genvar r = 0; r < num_pe_row; r++) begin : g_row
        fir_row #(
            .nb_taps(nb_taps)
        ) fir_row_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .act_data    (act_data[r]),
            .act_valid   (act_valid[r]),
            .taps        (taps),
            .result      (result[r]),
            .result_valid(result_valid[r])
        );
    end

    out_buffer #(
        .num_pe_row(num_pe_row),
        .out_depth (out_depth)
    ) out_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .result      (result),
        .result_valid(result_valid),
        .rd_en       (out_rd_en),
        .raddr       (out_raddr),
        .rdata       (out_data)
    );

endmodule

// File: source/out_buffer.sv
`timescale 1ns/10ps

module out_buffer #(
    parameter int num_pe_row = 4,
    parameter int out_depth = fpap_pkg::OUT_DEPTH,
    localparam int aw = $clog2(out_depth)
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  fpap_pkg::result_t [num_pe_row-1:0]   result,
    input  logic [num_pe_row-1:0]                result_valid,
    input  logic [num_pe_row-1:0]                rd_en,
    input  logic [num_pe_row-1:0][aw-1:0]        raddr,
    output fpap_pkg::result_t [num_pe_row-1:0]   rdata
);

    import fpap_pkg::*;

    for (genvar r = 0; r < num_pe_row; r++) begin : g_row
        logic [aw-1:0] wptr;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wptr <= '0;
            end else if (result_valid[r]) begin
                wptr <= (wptr == aw'(out_depth - 1)) ? '0 : wptr + 1'b1; // wraps
            end
        end

        sram_bank #(
            .payload_t(result_t),
            .depth    (out_depth)
        ) bank_i (
            .clk  (clk),
            .wr_en(result_valid[r]),
            .waddr(wptr),
            .wdata(result[r]),
            .rd_en(rd_en[r]),
            .raddr(raddr[r]),
            .rdata(rdata[r])
        );

        // no back-pressure, older results get overwritten
        a_wptr_wrap: assert property (@(posedge clk) disable iff (!rst_n)
            !(result_valid[r] && wptr == aw'(out_depth - 1)))
            else $error("output bank %0d write pointer wraps", r);
    end

endmodule

// File: source/fir_row.sv
`timescale 1ns/10ps

module fir_row #(
    parameter int nb_taps = 5
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  fpap_pkg::act_t                     act_data,
    input  logic                               act_valid,
    input  fpap_pkg::weight_t [nb_taps-1:0]    taps,
    output fpap_pkg::result_t                  result,
    output logic                               result_valid
);

    import fpap_pkg::*;

    act_t [nb_taps-1:0] dline; // tap 0 is the newest sample
    logic    shift_q;
    acc_t    sum;
    result_t result_q;
    logic    valid_q;

    // **************************************************
    // delay line
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dline   <= '0;
            shift_q <= 1'b0;
        end else begin
            shift_q <= act_valid;
            if (act_valid) begin
                dline[0] <= act_data;
                for (int k = 1; k < nb_taps; k++) begin
                    dline[k] <= dline[k-1];
                end
            end
        end
    end

    // sum of products over the shifted line
    always_comb begin
        sum = '0;
        for (int k = 0; k < nb_taps; k++) begin
            sum = sum + acc_t'(dline[k]) * acc_t'(taps[k]);
        end
    end

    // **************************************************
    // result register
    // **************************************************
    always_ff @(posedge clk) begin
        if (shift_q) begin
            result_q <= sat_to_result(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= shift_q; // one pulse per sample
        end
    end

    assign result       = result_q;
    assign result_valid = valid_q;

endmodule

// File: source/weight_buffer.sv
`timescale 1ns/10ps

module weight_buffer #(
    parameter int nb_taps = 5,
    parameter int wbuff_depth = fpap_pkg::WBUFF_DEPTH,
    localparam int aw = $clog2(wbuff_depth)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  logic [aw-1:0]                      waddr,
    input  fpap_pkg::weight_t                  wdata,
    input  logic                               rd_en,
    input  logic [aw-1:0]                      raddr,
    input  logic [nb_taps-1:0]                 tap_load_en,
    input  logic                               wreg_clear,
    output fpap_pkg::weight_t [nb_taps-1:0]    taps
);

    import fpap_pkg::*;

    weight_t              rdata;
    logic                 rd_q;
    logic [nb_taps-1:0]   load_q; // mask captured with the read
    weight_t [nb_taps-1:0] wreg;

    sram_bank #(
        .payload_t(weight_t),
        .depth    (wbuff_depth)
    ) bank_i (
        .clk  (clk),
        .wr_en(wr_en),
        .waddr(waddr),
        .wdata(wdata),
        .rd_en(rd_en),
        .raddr(raddr),
        .rdata(rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q   <= 1'b0;
            load_q <= '0;
        end else begin
            rd_q   <= rd_en;
            load_q <= tap_load_en;
        end
    end

    // **************************************************
    // tap weight registers
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n || wreg_clear) begin
            wreg <= '0; // clear wins over load
        end else if (rd_q) begin
            for (int k = 0; k < nb_taps; k++) begin
                if (load_q[k]) begin
                    wreg[k] <= rdata;
                end
            end
        end
    end

    assign taps = wreg;

    // a clear would silently swallow the pending load
    a_clear_vs_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(wreg_clear && rd_q && (|load_q)))
        else $error("wreg_clear collides with a pending tap load");

endmodule

// File: source/act_buffer.sv
`timescale 1ns/10ps

module act_buffer #(
    parameter int num_pe_row = 4,
    parameter int act_depth = fpap_pkg::ACT_DEPTH,
    localparam int aw = $clog2(act_depth)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [num_pe_row-1:0]                 wr_en,
    input  logic [num_pe_row-1:0][aw-1:0]         waddr,
    input  fpap_pkg::act_t [num_pe_row-1:0]       wdata,
    input  logic [num_pe_row-1:0]                 rd_en,
    input  logic [num_pe_row-1:0][aw-1:0]         raddr,
    input  fpap_pkg::act_t [num_pe_row-1:0]       dummy_act,
    input  logic                                  src_sel,
    output fpap_pkg::act_t [num_pe_row-1:0]       act_data,
    output logic [num_pe_row-1:0]                 act_valid
);

    import fpap_pkg::*;

    logic sel_q; // 1: bank, 0: dummy

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= 1'b1;
        end else begin
            sel_q <= src_sel;
        end
    end

    // **************************************************
    // one bank per row
    // **************************************************
    for (genvar r = 0; r < num_pe_row; r++) begin : g_row
        act_t bank_rdata;
        act_t dummy_q;
        logic rd_q;

        sram_bank #(
            .payload_t(act_t),
            .depth    (act_depth)
        ) bank_i (
            .clk  (clk),
            .wr_en(wr_en[r]),
            .waddr(waddr[r]),
            .wdata(wdata[r]),
            .rd_en(rd_en[r] & src_sel),
            .raddr(raddr[r]),
            .rdata(bank_rdata)
        );

        // dummy value lines up with the bank read
        always_ff @(posedge clk) begin
            if (rd_en[r] && !src_sel) begin
                dummy_q <= dummy_act[r];
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rd_q <= 1'b0;
            end else begin
                rd_q <= rd_en[r];
            end
        end

        assign act_data[r]  = sel_q ? bank_rdata : dummy_q;
        assign act_valid[r] = rd_q;
    end

endmodule

// File: source/sram_bank.sv
`timescale 1ns/10ps

module sram_bank #(
    parameter type payload_t = logic [15:0],
    parameter int depth = 256,
    localparam int aw = $clog2(depth)
) (
    input  logic           clk,
    input  logic           wr_en,
    input  logic [aw-1:0]  waddr,
    input  payload_t       wdata,
    input  logic           rd_en,
    input  logic [aw-1:0]  raddr,
    output payload_t       rdata
);

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[raddr];
        end
    end

    // non power of two depths leave a hole in the address space
    a_waddr_range: assert property (@(posedge clk) wr_en |-> (int'(waddr) < depth))
        else $error("sram_bank write address %0d beyond depth %0d", waddr, depth);

endmodule

// File: source/fpap_pkg.sv
package fpap_pkg;

    // **************************************************
    // data widths
    // **************************************************
    localparam int ACT_WIDTH    = 16;
    localparam int WEIGHT_WIDTH = 16;
    localparam int ACC_WIDTH    = 40; // room for nb_taps full products
    localparam int OUT_WIDTH    = 24;

    // default buffer depths, overridden from the top level
    localparam int ACT_DEPTH   = 256;
    localparam int WBUFF_DEPTH = 64;
    localparam int OUT_DEPTH   = 256;

    typedef logic signed [ACT_WIDTH-1:0]    act_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [OUT_WIDTH-1:0]    result_t;

    // result_t limits
    localparam result_t RESULT_MAX = {1'b0, {(OUT_WIDTH-1){1'b1}}};
    localparam result_t RESULT_MIN = {1'b1, {(OUT_WIDTH-1){1'b0}}};

    // **************************************************
    // clip a wide sum to the output range
    // **************************************************
    function automatic result_t sat_to_result(input acc_t acc);
        if (acc > acc_t'(RESULT_MAX)) begin
            return RESULT_MAX;
        end
        if (acc < acc_t'(RESULT_MIN)) begin
            return RESULT_MIN;
        end
        return result_t'(acc); // in range, low bits are exact
    endfunction

endpackage
